//--- design/rv_pkg.sv
// shared types for the rv32i core
// imported by every design module
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		logic [2:0] funct3;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		// sign-extended for the instruction format
		word_t imm;
		alu_op_e alu_op;
		logic imm_sel;
		logic reg_we;
	} decoded_t;

	typedef struct packed {
		logic write;
		word_t addr;
		word_t wdata;
		mem_size_e size;
	} mem_req_t;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_FETCH_WAIT,
		ST_DECODE,
		ST_EXECUTE,
		ST_MEM_WAIT
	} ctrl_state_e;

endpackage

//--- design/rv_alu.sv
// combinational alu for rv32i arithmetic, logic, shifts and compares
module rv_alu import rv_pkg::*; (
	input alu_op_e op,
	input word_t a,
	input word_t b,
	output word_t y
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_ADD:
				y = a + b;
			ALU_SUB:
				y = a - b;
			ALU_SLL:
				y = a << shamt;
			ALU_SRL:
				y = a >> shamt;
			ALU_SRA:
				y = word_t'($signed(a) >>> shamt);
			ALU_AND:
				y = a & b;
			ALU_OR:
				y = a | b;
			ALU_XOR:
				y = a ^ b;
			ALU_SLT:
				y = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:
				y = {31'b0, a < b};
			default:
				y = '0;
		endcase
	end

endmodule

//--- design/rv_regfile.sv
// 32 x 32-bit register file, two read ports and one write port
module rv_regfile import rv_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input reg_idx_t rs1_idx,
	input reg_idx_t rs2_idx,
	output word_t rs1_val,
	output word_t rs2_val,
	input logic we,
	input reg_idx_t rd_idx,
	input word_t rd_val
);

	word_t regs [32];

	assign rs1_val = regs[rs1_idx];
	assign rs2_val = regs[rs2_idx];

	// x0 is cleared at reset and never written
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (rdy_in && we && rd_idx != '0) begin
			regs[rd_idx] <= rd_val;
		end
	end

endmodule

//--- design/rv_decoder.sv
// combinational rv32i decoder
// builds the decoded-instruction struct with the format's immediate
module rv_decoder import rv_pkg::*; (
	input word_t instr,
	output decoded_t dec
);

	opcode_e opcode;
	logic [2:0] funct3;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];

	assign dec.opcode = opcode;
	assign dec.funct3 = funct3;
	assign dec.rd = instr[11:7];
	assign dec.rs1 = instr[19:15];
	assign dec.rs2 = instr[24:20];

	always_comb begin
		case (opcode)
			OP_LUI, OP_AUIPC:
				dec.imm = {instr[31:12], 12'b0};
			OP_JAL:
				dec.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			OP_BRANCH:
				dec.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			OP_STORE:
				dec.imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			// I format for loads, jalr and immediate alu ops
			default:
				dec.imm = {{21{instr[31]}}, instr[30:20]};
		endcase
	end

	// everything outside the alu opcodes adds
	always_comb begin
		dec.alu_op = ALU_ADD;
		if (opcode == OP_IMM || opcode == OP_REG) begin
			case (funct3)
				3'b000: dec.alu_op = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
				3'b001: dec.alu_op = ALU_SLL;
				3'b010: dec.alu_op = ALU_SLT;
				3'b011: dec.alu_op = ALU_SLTU;
				3'b100: dec.alu_op = ALU_XOR;
				// bit 30 picks sra and srai
				3'b101: dec.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
				3'b110: dec.alu_op = ALU_OR;
				default: dec.alu_op = ALU_AND;
			endcase
		end
	end

	assign dec.imm_sel = (opcode != OP_REG);

	always_comb begin
		case (opcode)
			OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG:
				dec.reg_we = 1'b1;
			default:
				dec.reg_we = 1'b0;
		endcase
	end

endmodule

//--- design/rv_control.sv
// instruction sequencer that runs fetch, decode, execute and memory access in turn
// holds the pc, the instruction register and the latched operands
module rv_control import rv_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input decoded_t dec,
	output word_t instr,
	output reg_idx_t rs1_idx,
	output reg_idx_t rs2_idx,
	input word_t rs1_val,
	input word_t rs2_val,
	output logic rd_we,
	output reg_idx_t rd_idx,
	output word_t rd_val,
	output alu_op_e alu_op,
	output word_t alu_a,
	output word_t alu_b,
	input word_t alu_y,
	output logic mem_start,
	output mem_req_t mem_req,
	input logic mem_done,
	input word_t mem_rdata
);

	ctrl_state_e state;
	word_t pc;
	word_t ir;
	word_t op1;
	word_t op2;
	word_t pc_plus4;
	word_t branch_target;
	word_t next_pc;
	word_t load_val;
	logic br_taken;
	logic is_mem;

	assign instr = ir;
	assign rs1_idx = dec.rs1;
	assign rs2_idx = dec.rs2;
	assign rd_idx = dec.rd;
	assign alu_op = dec.alu_op;

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc + dec.imm;
	assign is_mem = (dec.opcode == OP_LOAD) || (dec.opcode == OP_STORE);

	// lui goes through the adder as 0 + imm
	always_comb begin
		case (dec.opcode)
			OP_AUIPC: alu_a = pc;
			OP_LUI: alu_a = '0;
			default: alu_a = op1;
		endcase
	end
	assign alu_b = dec.imm_sel ? dec.imm : op2;

	always_comb begin
		case (dec.funct3)
			3'b000: br_taken = (op1 == op2);
			3'b001: br_taken = (op1 != op2);
			3'b100: br_taken = ($signed(op1) < $signed(op2));
			3'b101: br_taken = ($signed(op1) >= $signed(op2));
			3'b110: br_taken = (op1 < op2);
			3'b111: br_taken = (op1 >= op2);
			default: br_taken = 1'b0;
		endcase
	end

	always_comb begin
		case (dec.opcode)
			OP_JAL: next_pc = branch_target;
			OP_JALR: next_pc = {alu_y[31:1], 1'b0};
			OP_BRANCH: next_pc = br_taken ? branch_target : pc_plus4;
			default: next_pc = pc_plus4;
		endcase
	end

	// port returns bytes low-aligned with the upper bits zero
	always_comb begin
		case (dec.funct3)
			3'b000: load_val = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			3'b001: load_val = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			default: load_val = mem_rdata;
		endcase
	end

	// loads write back only once the port is done
	assign rd_we = (state == ST_EXECUTE && dec.reg_we && dec.opcode != OP_LOAD) ||
		(state == ST_MEM_WAIT && mem_done && dec.opcode == OP_LOAD);

	always_comb begin
		if (state == ST_MEM_WAIT)
			rd_val = load_val;
		else if (dec.opcode == OP_JAL || dec.opcode == OP_JALR)
			rd_val = pc_plus4;
		else
			rd_val = alu_y;
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= ST_FETCH;
			pc <= '0;
			mem_start <= 1'b0;
		end else if (rdy_in) begin
			mem_start <= 1'b0;
			case (state)
				ST_FETCH: begin
					mem_start <= 1'b1;
					mem_req.write <= 1'b0;
					mem_req.addr <= pc;
					mem_req.wdata <= '0;
					mem_req.size <= SIZE_WORD;
					state <= ST_FETCH_WAIT;
				end
				ST_FETCH_WAIT: begin
					if (mem_done) begin
						ir <= mem_rdata;
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					op1 <= rs1_val;
					op2 <= rs2_val;
					state <= ST_EXECUTE;
				end
				ST_EXECUTE: begin
					if (is_mem) begin
						mem_start <= 1'b1;
						mem_req.write <= (dec.opcode == OP_STORE);
						mem_req.addr <= alu_y;
						mem_req.wdata <= op2;
						mem_req.size <= mem_size_e'(dec.funct3[1:0]);
						state <= ST_MEM_WAIT;
					end else begin
						pc <= next_pc;
						state <= ST_FETCH;
					end
				end
				ST_MEM_WAIT: begin
					if (mem_done) begin
						pc <= pc_plus4;
						state <= ST_FETCH;
					end
				end
				default: state <= ST_FETCH;
			endcase
		end
	end

endmodule

//--- design/rv_mem_port.sv
// byte-serial memory port that turns word, half and byte requests into bus cycles
// reads need three cycles per byte, writes one
module rv_mem_port import rv_pkg::*; #(
	parameter int ADDR_W = 18
) (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input logic start,
	input mem_req_t req,
	output logic done,
	output word_t rdata,
	input byte_t mem_din,
	output byte_t mem_dout,
	output logic [ADDR_W-1:0] mem_a,
	output logic mem_wr
);

	logic busy;
	logic is_write;
	logic [1:0] byte_cnt;
	logic [1:0] last_byte;
	logic [1:0] phase;
	logic [1:0] req_last;
	word_t wdata_sr;

	always_comb begin
		case (req.size)
			SIZE_BYTE: req_last = 2'd0;
			SIZE_HALF: req_last = 2'd1;
			default: req_last = 2'd3;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			busy <= 1'b0;
			done <= 1'b0;
			mem_wr <= 1'b0;
			mem_a <= '0;
			byte_cnt <= '0;
			phase <= '0;
		end else if (rdy_in) begin
			done <= 1'b0;
			if (!busy) begin
				// first address goes out in the cycle after the start pulse
				if (start) begin
					busy <= 1'b1;
					is_write <= req.write;
					last_byte <= req_last;
					byte_cnt <= '0;
					phase <= 2'd1;
					mem_a <= req.addr[ADDR_W-1:0];
					mem_wr <= req.write;
					mem_dout <= req.wdata[7:0];
					wdata_sr <= req.wdata >> 8;
					rdata <= '0;
				end
			end else if (is_write) begin
				if (byte_cnt == last_byte) begin
					busy <= 1'b0;
					mem_wr <= 1'b0;
					done <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 2'd1;
					mem_a <= mem_a + 1'b1;
					mem_dout <= wdata_sr[7:0];
					wdata_sr <= wdata_sr >> 8;
				end
			end else begin
				// address, wait, then sample the registered byte
				case (phase)
					2'd0: begin
						mem_a <= mem_a + 1'b1;
						phase <= 2'd1;
					end
					2'd1: phase <= 2'd2;
					default: begin
						rdata[{byte_cnt, 3'b000} +: 8] <= mem_din;
						if (byte_cnt == last_byte) begin
							busy <= 1'b0;
							done <= 1'b1;
						end else begin
							byte_cnt <= byte_cnt + 2'd1;
							phase <= 2'd0;
						end
					end
				endcase
			end
		end
	end

endmodule

//--- design/rv_cpu.sv
// rv32i core top level with a byte-wide memory bus
// ADDR_W sets the width of the external address
module rv_cpu import rv_pkg::*; #(
	parameter int ADDR_W = 18
) (
	input logic clk_in,
	input logic rst_in,
	input logic rdy_in,
	input byte_t mem_din,
	output byte_t mem_dout,
	output logic [ADDR_W-1:0] mem_a,
	output logic mem_wr
);

	decoded_t dec;
	word_t instr;
	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	word_t rs1_val;
	word_t rs2_val;
	logic rd_we;
	reg_idx_t rd_idx;
	word_t rd_val;
	alu_op_e alu_op;
	word_t alu_a;
	word_t alu_b;
	word_t alu_y;
	logic mem_start;
	mem_req_t mem_req;
	logic mem_done;
	word_t mem_rdata;

	rv_control rv_control_i (
		.clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
		.dec(dec), .instr(instr),
		.rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.rd_we(rd_we), .rd_idx(rd_idx), .rd_val(rd_val),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_y(alu_y),
		.mem_start(mem_start), .mem_req(mem_req),
		.mem_done(mem_done), .mem_rdata(mem_rdata)
	);

	rv_decoder rv_decoder_i (.instr(instr), .dec(dec));

	rv_regfile rv_regfile_i (
		.clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
		.rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.we(rd_we), .rd_idx(rd_idx), .rd_val(rd_val)
	);

	rv_alu rv_alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

	rv_mem_port #(.ADDR_W(ADDR_W)) rv_mem_port_i (
		.clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
		.start(mem_start), .req(mem_req), .done(mem_done), .rdata(mem_rdata),
		.mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
	);

endmodule

//--- sim/tb_clock.sv
// free-running testbench clock, 10 ns period
module tb_clock (
	output logic clk_in
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

endmodule

//--- sim/tb_cpu.sv
// testbench for the rv32i core with a random program and an instruction-set model
// every byte the core writes is compared in order with the bytes the model stores
module tb_cpu import rv_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ADDR_W = 18;
	localparam int MEM_SIZE = 1 << 17;
	localparam int MAX_CYCLES = 200000;
	localparam word_t HALT_ADDR = 32'h30004;

	logic clk_in;
	logic rst_in = 1'b1;
	logic rdy_in = 1'b1;
	byte_t mem_din = '0;
	byte_t mem_dout;
	logic [ADDR_W-1:0] mem_a;
	logic mem_wr;

	byte_t mem [MEM_SIZE];
	byte_t ref_mem [MEM_SIZE];
	word_t prog [$];
	word_t exp_addr [$];
	byte_t exp_data [$];
	int write_idx = 0;
	logic halted = 1'b0;

	tb_clock clock_i (.clk_in(clk_in));

	rv_cpu #(.ADDR_W(ADDR_W)) rv_cpu_i (
		.clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
		.mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
	);

	function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_s(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_u(int imm, int rd, logic [6:0] op);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_j(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	// alt selects sub and sra
	function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped after an error");
	endtask

	task automatic check_value(string name, word_t expected, word_t actual);
		if (expected !== actual) begin
			$display("** Error: %s: expected %h, actual %h", name, expected, actual);
			abort_run("a bus write differs from the model");
		end
	endtask

	// stores go to x2 plus a small offset inside the data area
	task automatic add_store(int rs, int f3);
		prog.push_back(enc_s($urandom_range(0, 251), rs, 2, f3));
	endtask

	task automatic add_random_stores(int count);
		for (int i = 0; i < count; i++)
			add_store($urandom_range(0, 15), $urandom_range(0, 2));
	endtask

	task automatic build_program();
		int load_f3 [5] = '{0, 1, 2, 4, 5};
		int branch_f3 [6] = '{0, 1, 4, 5, 6, 7};
		int rd;
		int rs1;
		int rs2;
		int f3;
		int k;
		int imm;
		for (int i = 0; i < MEM_SIZE; i++)
			mem[i] = byte_t'(i * 13 ^ (i >> 8) ^ (i >> 16));
		// x2 holds the data area base 0x1000
		prog.push_back(enc_u(1, 2, OP_LUI));
		for (int r = 3; r < 16; r++) begin
			prog.push_back(enc_u($urandom, r, OP_LUI));
			prog.push_back(enc_i($urandom, r, 0, r, OP_IMM));
		end
		for (int n = 0; n < 70; n++) begin
			rd = $urandom_range(3, 15);
			rs1 = $urandom_range(0, 15);
			rs2 = $urandom_range(0, 15);
			f3 = $urandom_range(0, 7);
			k = $urandom_range(1, 3);
			case ($urandom_range(0, 9))
				0, 1: begin
					imm = $urandom;
					if (f3 == 1)
						imm = imm & 32'h1f;
					else if (f3 == 5)
						imm = imm & 32'h41f;
					prog.push_back(enc_i(imm, rs1, f3, rd, OP_IMM));
					add_store(rd, 2);
				end
				2, 3: begin
					imm = (f3 == 0 || f3 == 5) ? $urandom_range(0, 1) * 32 : 0;
					prog.push_back(enc_r(imm, rs2, rs1, f3, rd));
					add_store(rd, 2);
				end
				4: begin
					prog.push_back(enc_u($urandom, rd, $urandom_range(0, 1) ? OP_LUI : OP_AUIPC));
					add_store(rd, 2);
				end
				5: begin
					f3 = load_f3[$urandom_range(0, 4)];
					prog.push_back(enc_i($urandom_range(0, 251), 2, f3, rd, OP_LOAD));
					add_store(rd, 2);
				end
				6: add_store(rs2, $urandom_range(0, 2));
				7: begin
					f3 = branch_f3[$urandom_range(0, 5)];
					prog.push_back(enc_b(4 * (k + 1), rs2, rs1, f3));
					add_random_stores(k);
				end
				8: begin
					prog.push_back(enc_j(4 * (k + 1), rd));
					add_random_stores(k);
					add_store(rd, 2);
				end
				default: begin
					// odd offset so the target drops bit 0
					prog.push_back(enc_u(0, 1, OP_AUIPC));
					prog.push_back(enc_i(9 + 4 * k, 1, 0, rd, OP_JALR));
					add_random_stores(k);
					add_store(rd, 2);
				end
			endcase
		end
		prog.push_back(enc_u(32'h30, 1, OP_LUI));
		prog.push_back(enc_s(4, 0, 1, 0));
		for (int i = 0; i < prog.size(); i++)
			for (int j = 0; j < 4; j++)
				mem[4 * i + j] = prog[i][8 * j +: 8];
		for (int i = 0; i < MEM_SIZE; i++)
			ref_mem[i] = mem[i];
	endtask

	// behavioral rv32i over ref_mem that records each stored byte in order
	task automatic run_model();
		word_t x [32];
		word_t pc;
		word_t ins;
		word_t a;
		word_t b;
		word_t r;
		word_t addr;
		word_t val;
		word_t next_pc;
		logic [2:0] f3;
		logic take;
		logic wr;
		logic stop;
		int steps;
		stop = 1'b0;
		steps = 0;
		pc = '0;
		for (int i = 0; i < 32; i++)
			x[i] = '0;
		while (!stop && steps < 5000) begin
			for (int i = 0; i < 4; i++)
				ins[8 * i +: 8] = ref_mem[17'(pc + i)];
			f3 = ins[14:12];
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			r = pc + 4;
			wr = 1'b0;
			next_pc = pc + 4;
			case (ins[6:0])
				OP_LUI: begin
					r = {ins[31:12], 12'b0};
					wr = 1'b1;
				end
				OP_AUIPC: begin
					r = pc + {ins[31:12], 12'b0};
					wr = 1'b1;
				end
				OP_JAL: begin
					wr = 1'b1;
					next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				OP_JALR: begin
					wr = 1'b1;
					next_pc = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
				end
				OP_BRANCH: begin
					case (f3)
						3'b000: take = (a == b);
						3'b001: take = (a != b);
						3'b100: take = ($signed(a) < $signed(b));
						3'b101: take = ($signed(a) >= $signed(b));
						3'b110: take = (a < b);
						default: take = (a >= b);
					endcase
					if (take)
						next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				end
				OP_LOAD: begin
					addr = a + {{20{ins[31]}}, ins[31:20]};
					for (int i = 0; i < 4; i++)
						val[8 * i +: 8] = ref_mem[17'(addr + i)];
					case (f3)
						3'b000: r = {{24{val[7]}}, val[7:0]};
						3'b001: r = {{16{val[15]}}, val[15:0]};
						3'b100: r = {24'b0, val[7:0]};
						3'b101: r = {16'b0, val[15:0]};
						default: r = val;
					endcase
					wr = 1'b1;
				end
				OP_STORE: begin
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					for (int i = 0; i < (1 << f3[1:0]); i++) begin
						exp_addr.push_back(addr + i);
						exp_data.push_back(b[8 * i +: 8]);
						ref_mem[17'(addr + i)] = b[8 * i +: 8];
					end
					stop = (addr == HALT_ADDR);
				end
				OP_IMM: begin
					r = alu_model(f3, f3 == 3'b101 && ins[30], a, {{20{ins[31]}}, ins[31:20]});
					wr = 1'b1;
				end
				OP_REG: begin
					r = alu_model(f3, ins[30], a, b);
					wr = 1'b1;
				end
				default: ;
			endcase
			if (wr && ins[11:7] != 5'd0)
				x[ins[11:7]] = r;
			pc = next_pc;
			steps++;
		end
		if (!stop)
			abort_run("the model never reached the halt store");
	endtask

	// registered read with no storage for I/O above 128 KB
	always @(posedge clk_in) begin
		mem_din <= mem[mem_a[16:0]];
		if (mem_wr && !mem_a[17])
			mem[mem_a[16:0]] = mem_dout;
	end

	// a write byte counts once at the edge where rdy_in lets the port advance
	always @(negedge clk_in) begin
		if (!rst_in && rdy_in && mem_wr) begin
			if (write_idx >= exp_addr.size()) begin
				abort_run("the core wrote more bytes than the model");
			end else begin
				check_value($sformatf("write %0d address", write_idx), exp_addr[write_idx],
					word_t'(mem_a));
				check_value($sformatf("write %0d data", write_idx),
					word_t'(exp_data[write_idx]), word_t'(mem_dout));
				write_idx++;
				halted = (write_idx == exp_addr.size());
			end
		end
	end

	initial begin
		int cycles;
		int stall;
		cycles = 0;
		stall = 0;
		void'($urandom(32'h8e12));
		build_program();
		run_model();
		repeat (2) @(posedge clk_in);
		rst_in <= 1'b0;
		// random stretches with rdy_in low
		while (!halted && cycles < MAX_CYCLES) begin
			@(posedge clk_in);
			if (stall > 0) begin
				rdy_in <= 1'b0;
				stall--;
			end else if ($urandom_range(0, 19) == 0) begin
				rdy_in <= 1'b0;
				stall = $urandom_range(0, 6);
			end else begin
				rdy_in <= 1'b1;
			end
			cycles++;
		end
		if (halted) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			abort_run("timed out waiting for the halt write");
		end
	end

endmodule

//--- all.f
design/rv_pkg.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_decoder.sv
design/rv_control.sv
design/rv_mem_port.sv
design/rv_cpu.sv
sim/tb_clock.sv
sim/tb_cpu.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_cpu -f all.f --Mdir obj_dir -o tb_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed"
	exit "$status"
fi

./obj_dir/tb_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation reported a failure"
	exit "$status"
fi
exit 0
